// ==== source/fmac_stat_config.svh ====
`ifndef FMAC_STAT_CONFIG_SVH
`define FMAC_STAT_CONFIG_SVH

// ==============================
// widths
// ==============================
`define FMAC_DATA_W         32      // host read word
`define FMAC_ADDR_W         16      // host address, page in bits 15:12
`define FMAC_STAT_ADDR_W    10      // external stat group address
`define FMAC_NUM_REGU       8       // plain 32 bit regular words

// ==============================
// regular group byte offsets
// ==============================
// bit 2 picks lo/hi half on the two 64 bit rx counters
`define FMAC_CTRL_OFS       10'h000
`define FMAC_TX_PKT_OFS     10'h020
`define FMAC_RX_PKT_OFS     10'h028 // 64 bit
`define FMAC_TX_BYTE_OFS    10'h030
`define FMAC_RX_BYTE_OFS    10'h038 // 64 bit
`define FMAC_UNDERSIZE_OFS  10'h040
`define FMAC_CRC_ERR_OFS    10'h048
`define FMAC_OVERRUN_OFS    10'h050
`define FMAC_LINK_ERR_OFS   10'h058
`define FMAC_PHY_STAT_OFS   10'h068

// ==============================
// pipeline
// ==============================
// start -> sel -> live_hi settle, then latch the hi copy
`define FMAC_HI_CAPTURE_DLY 3

`endif

// ==== source/fmac_stat_pkg.sv ====
`default_nettype none

`include "fmac_stat_config.svh"

package fmac_stat_pkg;

	// host address, regular register view
	typedef struct packed {
		logic [`FMAC_ADDR_W-13:0]      page;      // bits 15:12, compared to sys_addr
		logic                          stat_grp;  // bit 11, external stat group
		logic                          unused;    // bit 10
		logic [6:0]                    index;     // word index, bits 9:3
		logic                          upper;     // hi half of a 64 bit reg
		logic [1:0]                    byte_ofs;  // always 0 from host
	} fmac_regu_view_s;

	// same word seen by the stat group
	typedef struct packed {
		logic [`FMAC_ADDR_W-13:0]      page;
		logic                          stat_grp;
		logic                          unused;
		logic [`FMAC_STAT_ADDR_W-1:0]  stat_addr;
	} fmac_stat_view_s;

	typedef union packed {
		fmac_regu_view_s regu;
		fmac_stat_view_s stat;
	} fmac_host_addr_u;

	// counters from the mac, offset order
	typedef struct packed {
		logic [`FMAC_DATA_W-1:0] ctrl;        // 0x00
		logic [`FMAC_DATA_W-1:0] tx_pkt;      // 0x20
		logic [`FMAC_DATA_W-1:0] rx_pkt_lo;   // 0x28
		logic [`FMAC_DATA_W-1:0] rx_pkt_hi;   // 0x2c
		logic [`FMAC_DATA_W-1:0] tx_byte;     // 0x30
		logic [`FMAC_DATA_W-1:0] rx_byte_lo;  // 0x38
		logic [`FMAC_DATA_W-1:0] rx_byte_hi;  // 0x3c
		logic [`FMAC_DATA_W-1:0] undersize;   // 0x40
		logic [`FMAC_DATA_W-1:0] crc_err;     // 0x48
		logic [`FMAC_DATA_W-1:0] overrun;     // 0x50
		logic [`FMAC_DATA_W-1:0] link_err;    // 0x58
		logic [`FMAC_DATA_W-1:0] phy_stat;    // 0x68
	} fmac_regu_cnt_s;

	typedef struct packed {
		logic [`FMAC_DATA_W-1:0] lo;
		logic [`FMAC_DATA_W-1:0] hi;
	} fmac_stat_grp_s;

	typedef struct packed {
		fmac_host_addr_u addr;
		logic            start;   // one cycle, addr already stable
		logic            done;    // one cycle, end of access
	} fmac_rd_req_s;

	// registered decode
	typedef struct packed {
		logic [`FMAC_NUM_REGU-1:0] regu;       // one-hot, plain 32 bit words
		logic                      rx_pkt64;
		logic                      rx_byte64;
		logic                      stat_grp;
		logic                      upper;
		logic [8:0]                tag;        // addr 11:3
		logic                      page_hit;
	} fmac_sel_s;

endpackage

`default_nettype wire

// ==== source/fmac_addr_decode.sv ====
`default_nettype none

`include "fmac_stat_config.svh"

module fmac_addr_decode
(
	input  wire logic                             clk,
	input  wire logic                             reset_,
	input  wire fmac_stat_pkg::fmac_host_addr_u   addr,
	input  wire logic [`FMAC_ADDR_W-13:0]         sys_addr,      // strap
	output fmac_stat_pkg::fmac_sel_s              sel,
	output logic [`FMAC_STAT_ADDR_W-1:0]          stat_grp_addr,
	output logic                                  stat_grp_sel
);
	import fmac_stat_pkg::*;

	// ==============================
	// offset table
	// ==============================
	// slot order here sets the regu word order in fmac_counter_mux
	localparam logic [`FMAC_STAT_ADDR_W-1:0] REGU_OFS [`FMAC_NUM_REGU] = '{
		`FMAC_CTRL_OFS,
		`FMAC_TX_PKT_OFS,
		`FMAC_TX_BYTE_OFS,
		`FMAC_UNDERSIZE_OFS,
		`FMAC_CRC_ERR_OFS,
		`FMAC_OVERRUN_OFS,
		`FMAC_LINK_ERR_OFS,
		`FMAC_PHY_STAT_OFS
	};
	localparam logic [`FMAC_STAT_ADDR_W-1:0] RX_PKT_OFS  = `FMAC_RX_PKT_OFS;
	localparam logic [`FMAC_STAT_ADDR_W-1:0] RX_BYTE_OFS = `FMAC_RX_BYTE_OFS;

	fmac_sel_s sel_d;      // decode of the live address
	logic      regu_grp;   // bit 11 low, regular group

	// ==============================
	// decode
	// ==============================
	assign regu_grp = !addr.regu.stat_grp;

	always_comb
	begin
		sel_d = '0;
		// word compare only, byte_ofs and bit 10 ignored
		for (int i = 0; i < `FMAC_NUM_REGU; i++)
			sel_d.regu[i] = regu_grp & (addr.regu.index == REGU_OFS[i][9:3]);
		sel_d.rx_pkt64  = regu_grp & (addr.regu.index == RX_PKT_OFS[9:3]);
		sel_d.rx_byte64 = regu_grp & (addr.regu.index == RX_BYTE_OFS[9:3]);
		sel_d.stat_grp  = addr.regu.stat_grp;
		sel_d.upper     = addr.regu.upper;        // bit 2, same in both views
		sel_d.tag       = {addr.regu.stat_grp, addr.regu.unused, addr.regu.index};
		sel_d.page_hit  = (addr.regu.page == sys_addr);   // this mac's page
	end

	// ==============================
	// registers
	// ==============================
	always_ff @(posedge clk)
	begin
		if (!reset_)
		begin
			sel          <= '0;
			stat_grp_sel <= 1'b0;
		end
		else
		begin
			sel          <= sel_d;
			stat_grp_sel <= addr.stat.stat_grp;   // no further decode, bit 11 alone
		end
	end

	// group only sees 64 bit words, low three bits forced
	always_ff @(posedge clk)
		stat_grp_addr <= {addr.stat.stat_addr[`FMAC_STAT_ADDR_W-1:3], 3'b000};

endmodule

`default_nettype wire

// ==== source/fmac_counter_mux.sv ====
`default_nettype none

`include "fmac_stat_config.svh"

module fmac_counter_mux
(
	input  wire logic                            clk,
	input  wire logic                            reset_,
	input  wire fmac_stat_pkg::fmac_sel_s        sel,
	input  wire fmac_stat_pkg::fmac_regu_cnt_s   regu_cnt,
	input  wire fmac_stat_pkg::fmac_stat_grp_s   stat_grp_dout,
	input  wire logic [`FMAC_DATA_W-1:0]         hold_hi,     // atomic copy
	input  wire logic                            hold_en,
	output logic [`FMAC_DATA_W-1:0]              live_hi,
	output logic [`FMAC_DATA_W-1:0]              regdout
);
	logic [`FMAC_DATA_W-1:0] regu_word [`FMAC_NUM_REGU];
	logic [`FMAC_DATA_W-1:0] lo_mux;
	logic [`FMAC_DATA_W-1:0] hi_mux;
	logic [`FMAC_DATA_W-1:0] regu_lo;    // registered low word

	// ==============================
	// regular words
	// ==============================
	// same slot order as the offset table in fmac_addr_decode
	assign regu_word[0] = regu_cnt.ctrl;
	assign regu_word[1] = regu_cnt.tx_pkt;
	assign regu_word[2] = regu_cnt.tx_byte;
	assign regu_word[3] = regu_cnt.undersize;
	assign regu_word[4] = regu_cnt.crc_err;
	assign regu_word[5] = regu_cnt.overrun;
	assign regu_word[6] = regu_cnt.link_err;
	assign regu_word[7] = regu_cnt.phy_stat;

	// and-or mux, selects are one-hot or zero
	always_comb
	begin
		lo_mux = {`FMAC_DATA_W{sel.rx_pkt64}}  & regu_cnt.rx_pkt_lo
		       | {`FMAC_DATA_W{sel.rx_byte64}} & regu_cnt.rx_byte_lo;
		for (int i = 0; i < `FMAC_NUM_REGU; i++)
			lo_mux = lo_mux | ({`FMAC_DATA_W{sel.regu[i]}} & regu_word[i]);
	end

	// live hi half, stat group is all 64 bit
	assign hi_mux = {`FMAC_DATA_W{sel.rx_pkt64}}  & regu_cnt.rx_pkt_hi
	              | {`FMAC_DATA_W{sel.rx_byte64}} & regu_cnt.rx_byte_hi
	              | {`FMAC_DATA_W{sel.stat_grp}}  & stat_grp_dout.hi;

	// ==============================
	// stage 2
	// ==============================
	always_ff @(posedge clk)
	begin
		regu_lo <= lo_mux;
		live_hi <= hi_mux;    // also feeds the atomic capture
	end

	// ==============================
	// stage 3, read word
	// ==============================
	always_ff @(posedge clk)
	begin
		if (!reset_)
			regdout <= '0;
		else if (sel.upper)
			regdout <= hold_en ? hold_hi : live_hi;    // copy from the low read wins
		else if (sel.stat_grp)
			regdout <= stat_grp_dout.lo;
		else
			regdout <= regu_lo;                        // 0 when nothing mapped
	end

endmodule

`default_nettype wire

// ==== source/fmac_atomic_hi.sv ====
`default_nettype none

`include "fmac_stat_config.svh"

module fmac_atomic_hi
(
	input  wire logic                      clk,
	input  wire logic                      reset_,
	input  wire logic                      rd_start,
	input  wire logic                      rd_done,
	input  wire fmac_stat_pkg::fmac_sel_s  sel,
	input  wire logic [`FMAC_DATA_W-1:0]   live_hi,
	input  wire logic                      rx_auto_clr_en,
	input  wire logic                      tx_auto_clr_en,
	output logic [`FMAC_DATA_W-1:0]        hold_hi,
	output logic                           hold_en,
	output logic                           rx_clr_en,
	output logic                           tx_clr_en
);
	logic [`FMAC_HI_CAPTURE_DLY-1:0] start_dly;   // start shift chain
	logic                            atomic_lo;   // low half of a 64 bit reg
	logic                            capture;
	logic                            tag_match;
	logic                            hi_match;    // high read of the tagged reg
	logic                            valid;
	logic [8:0]                      tag;
	logic                            done_dly;

	// ==============================
	// capture timing
	// ==============================
	// the host reads the low half first, hi half is frozen here
	assign atomic_lo = !sel.upper & (sel.rx_pkt64 | sel.rx_byte64 | sel.stat_grp);
	assign capture   = start_dly[`FMAC_HI_CAPTURE_DLY-1] & atomic_lo;

	always_ff @(posedge clk)
	begin
		if (!reset_)
			start_dly <= '0;
		else
			start_dly <= {start_dly[`FMAC_HI_CAPTURE_DLY-2:0], rd_start};
	end

	// copy and tag
	always_ff @(posedge clk)
	begin
		if (capture)
		begin
			hold_hi <= live_hi;
			tag     <= sel.tag;
		end
	end

	// ==============================
	// valid and hold
	// ==============================
	assign tag_match = (sel.tag == tag);
	assign hi_match  = valid & tag_match & sel.upper;

	always_ff @(posedge clk)
	begin
		if (!reset_)
			valid <= 1'b0;
		else if (capture)
			valid <= 1'b1;
		else if (rd_done & hi_match)
			valid <= 1'b0;    // copy used once
	end

	always_ff @(posedge clk)
	begin
		if (!reset_)
			hold_en <= 1'b0;
		else if (rd_done)
			hold_en <= 1'b0;    // drop at end of access
		else if (hi_match)
			hold_en <= 1'b1;    // early enough for stage 3
	end

	// ==============================
	// clear on read
	// ==============================
	// pulse two cycles after done, sel still holds the read's page
	always_ff @(posedge clk)
	begin
		if (!reset_)
		begin
			done_dly  <= 1'b0;
			rx_clr_en <= 1'b0;
			tx_clr_en <= 1'b0;
		end
		else
		begin
			done_dly  <= rd_done;
			rx_clr_en <= done_dly & sel.page_hit & rx_auto_clr_en;
			tx_clr_en <= done_dly & sel.page_hit & tx_auto_clr_en;
		end
	end

endmodule

`default_nettype wire

// ==== source/fmac_stat_regs.sv ====
`default_nettype none

`include "fmac_stat_config.svh"

module fmac_stat_regs
(
	input  wire logic                            clk,
	input  wire logic                            reset_,
	// host side
	input  wire fmac_stat_pkg::fmac_rd_req_s     rd_req,
	// mac counters
	input  wire fmac_stat_pkg::fmac_regu_cnt_s   regu_cnt,
	// external statistics group
	input  wire fmac_stat_pkg::fmac_stat_grp_s   stat_grp_dout,
	// straps
	input  wire logic [`FMAC_ADDR_W-13:0]        sys_addr,
	input  wire logic                            rx_auto_clr_en,
	input  wire logic                            tx_auto_clr_en,
	output logic [`FMAC_STAT_ADDR_W-1:0]         stat_grp_addr,
	output logic                                 stat_grp_sel,
	output logic [`FMAC_DATA_W-1:0]              regdout,
	output logic                                 rx_clr_en,
	output logic                                 tx_clr_en
);
	import fmac_stat_pkg::*;

	fmac_sel_s               sel;       // registered decode
	logic [`FMAC_DATA_W-1:0] live_hi;
	logic [`FMAC_DATA_W-1:0] hold_hi;
	logic                    hold_en;

	// ==============================
	// decode, cycle 1
	// ==============================
	fmac_addr_decode i_decode
	(
		.clk           (clk),
		.reset_        (reset_),
		.addr          (rd_req.addr),
		.sys_addr      (sys_addr),
		.sel           (sel),
		.stat_grp_addr (stat_grp_addr),
		.stat_grp_sel  (stat_grp_sel)
	);

	// ==============================
	// mux, cycles 2 and 3
	// ==============================
	fmac_counter_mux i_mux
	(
		.clk           (clk),
		.reset_        (reset_),
		.sel           (sel),
		.regu_cnt      (regu_cnt),
		.stat_grp_dout (stat_grp_dout),
		.hold_hi       (hold_hi),
		.hold_en       (hold_en),
		.live_hi       (live_hi),
		.regdout       (regdout)
	);

	// atomic hi copy and clear pulses
	fmac_atomic_hi i_atomic
	(
		.clk            (clk),
		.reset_         (reset_),
		.rd_start       (rd_req.start),
		.rd_done        (rd_req.done),
		.sel            (sel),
		.live_hi        (live_hi),
		.rx_auto_clr_en (rx_auto_clr_en),
		.tx_auto_clr_en (tx_auto_clr_en),
		.hold_hi        (hold_hi),
		.hold_en        (hold_en),
		.rx_clr_en      (rx_clr_en),
		.tx_clr_en      (tx_clr_en)
	);

endmodule

`default_nettype wire

// ==== dv/fmac_stat_props.sv ====
`default_nettype none

`include "fmac_stat_config.svh"

module fmac_stat_props
(
	input  wire logic                        clk,
	input  wire logic                        reset_,
	input  wire fmac_stat_pkg::fmac_sel_s    sel,
	input  wire logic [`FMAC_DATA_W-1:0]     regdout,
	input  wire logic                        rx_clr_en,
	input  wire logic                        tx_clr_en
);
	import fmac_stat_pkg::*;

	// ==============================
	// decode
	// ==============================
	a_regu_onehot: assert property (@(posedge clk) disable iff (!reset_)
		$onehot0(sel.regu))
		else $error("regular select has more than one bit set");

	// ==============================
	// clear on read
	// ==============================
	a_rx_clr_len: assert property (@(posedge clk) disable iff (!reset_)
		rx_clr_en |=> !rx_clr_en)
		else $error("rx clear pulse longer than one cycle");
	a_tx_clr_len: assert property (@(posedge clk) disable iff (!reset_)
		tx_clr_en |=> !tx_clr_en)
		else $error("tx clear pulse longer than one cycle");
	a_clr_page: assert property (@(posedge clk) disable iff (!reset_)
		(rx_clr_en | tx_clr_en) |-> sel.page_hit)
		else $error("clear pulse outside this mac's page");

	// reset values one edge into reset
	a_reset_vals: assert property (@(posedge clk)
		!reset_ |=> (regdout == '0 && !rx_clr_en && !tx_clr_en && sel == '0))
		else $error("outputs not cleared by reset");

endmodule

bind fmac_stat_regs fmac_stat_props i_props
(
	.clk       (clk),
	.reset_    (reset_),
	.sel       (sel),
	.regdout   (regdout),
	.rx_clr_en (rx_clr_en),
	.tx_clr_en (tx_clr_en)
);

`default_nettype wire

// ==== dv/fmac_stat_tb.sv ====
`default_nettype none

`include "fmac_stat_config.svh"

module fmac_stat_tb;
	import fmac_stat_pkg::*;

	localparam int REGU_READS = 200;
	localparam int STAT_READS = 40;
	localparam int FIXED_READS = 16;                           // atomic, mismatch and clear reads
	localparam int TOTAL_READS = REGU_READS + STAT_READS + FIXED_READS;
	localparam int WATCHDOG_CYCLES = TOTAL_READS * 20 + 10 + 20;

	logic                   clk;
	logic                   reset_;
	fmac_rd_req_s           rd_req;
	fmac_regu_cnt_s         regu_cnt;
	fmac_stat_grp_s         stat_grp_dout;
	logic [3:0]             sys_addr;
	logic                   rx_auto_clr_en;
	logic                   tx_auto_clr_en;
	logic [9:0]             stat_grp_addr;
	logic                   stat_grp_sel;
	logic [31:0]            regdout;
	logic                   rx_clr_en;
	logic                   tx_clr_en;

	logic [63:0]            stat_mem [128];   // external group model with hi in 63:32
	logic [31:0]            rng_state;
	int                     err_cnt;

	fmac_stat_regs i_dut
	(
		.clk            (clk),
		.reset_         (reset_),
		.rd_req         (rd_req),
		.regu_cnt       (regu_cnt),
		.stat_grp_dout  (stat_grp_dout),
		.sys_addr       (sys_addr),
		.rx_auto_clr_en (rx_auto_clr_en),
		.tx_auto_clr_en (tx_auto_clr_en),
		.stat_grp_addr  (stat_grp_addr),
		.stat_grp_sel   (stat_grp_sel),
		.regdout        (regdout),
		.rx_clr_en      (rx_clr_en),
		.tx_clr_en      (tx_clr_en)
	);

	// group answers from its registered address
	always_comb
	begin
		stat_grp_dout.lo = stat_mem[stat_grp_addr[9:3]][31:0];
		stat_grp_dout.hi = stat_mem[stat_grp_addr[9:3]][63:32];
	end

	always #20 clk = ~clk;

	// ==============================
	// helpers
	// ==============================
	function automatic logic [31:0] next_rand();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return rng_state;
	endfunction

	task automatic compare_word(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act)
		begin
			err_cnt++;
			$display("ERR %s expected %h actual %h", name, exp, act);
			$display("Simulation finished: FAIL");
			$fatal(1, "mismatch");
		end
	endtask

	// register map model of live values
	function automatic logic [31:0] model_word(input logic [15:0] a);
		logic [9:0] ofs;
		ofs = {a[9:3], 3'b000};
		if (a[11])
			return a[2] ? stat_mem[a[9:3]][63:32] : stat_mem[a[9:3]][31:0];
		if (a[2])
		begin
			case (ofs)
				10'h028: return regu_cnt.rx_pkt_hi;
				10'h038: return regu_cnt.rx_byte_hi;
				default: return 32'h0;          // no hi half on 32 bit words
			endcase
		end
		case (ofs)
			10'h000: return regu_cnt.ctrl;
			10'h020: return regu_cnt.tx_pkt;
			10'h028: return regu_cnt.rx_pkt_lo;
			10'h030: return regu_cnt.tx_byte;
			10'h038: return regu_cnt.rx_byte_lo;
			10'h040: return regu_cnt.undersize;
			10'h048: return regu_cnt.crc_err;
			10'h050: return regu_cnt.overrun;
			10'h058: return regu_cnt.link_err;
			10'h068: return regu_cnt.phy_stat;
			default: return 32'h0;
		endcase
	endfunction

	// 12 mapped words then a few holes
	function automatic logic [9:0] regu_addr_pick(input int idx);
		case (idx)
			0:  return 10'h000;
			1:  return 10'h020;
			2:  return 10'h028;
			3:  return 10'h02c;
			4:  return 10'h030;
			5:  return 10'h038;
			6:  return 10'h03c;
			7:  return 10'h040;
			8:  return 10'h048;
			9:  return 10'h050;
			10: return 10'h058;
			11: return 10'h068;
			12: return 10'h008;
			13: return 10'h010;
			14: return 10'h060;
			15: return 10'h070;
			16: return 10'h024;   // hi half of a 32 bit word
			default: return 10'h0c4;
		endcase
	endfunction

	// one host read with the clear pulses checked after done
	task automatic host_read(input logic [15:0] a, input logic [31:0] exp, input string name);
		logic clr_hit;
		@(posedge clk);
		#2 rd_req.addr = a;
		@(posedge clk);
		#2 rd_req.start = 1'b1;
		@(posedge clk);
		#2 rd_req.start = 1'b0;
		repeat (8) @(posedge clk);
		#2;
		compare_word({name, " regdout"}, exp, regdout);
		compare_word({name, " stat_grp_addr"}, {22'h0, a[9:3], 3'b000}, {22'h0, stat_grp_addr});
		compare_word({name, " stat_grp_sel"}, {31'h0, a[11]}, {31'h0, stat_grp_sel});
		clr_hit = (a[15:12] == sys_addr);
		rd_req.done = 1'b1;
		for (int k = 1; k <= 4; k++)
		begin
			@(posedge clk);
			#2 rd_req.done = 1'b0;
			compare_word({name, " rx_clr_en"}, {31'h0, (k == 2) & clr_hit & rx_auto_clr_en},
				{31'h0, rx_clr_en});
			compare_word({name, " tx_clr_en"}, {31'h0, (k == 2) & clr_hit & tx_auto_clr_en},
				{31'h0, tx_clr_en});
		end
	endtask

	// ==============================
	// watchdog
	// ==============================
	initial
	begin
		#(WATCHDOG_CYCLES * 40);
		$display("timeout, reads did not finish in time");
		$display("Simulation finished: FAIL");
		$fatal(1, "timeout");
	end

	// ==============================
	// main sequence
	// ==============================
	initial
	begin
		logic [15:0] a;
		logic [31:0] old_hi;
		logic [31:0] r;
		clk            = 1'b0;
		reset_         = 1'b0;
		rd_req         = '0;
		rd_req.addr    = 16'h0000;   // ctrl word while idle
		sys_addr       = 4'h0;
		rx_auto_clr_en = 1'b0;
		tx_auto_clr_en = 1'b0;
		err_cnt        = 0;
		rng_state      = 32'h9ec47d16;
		regu_cnt       = '0;
		for (int i = 0; i < 12; i++)
			regu_cnt[i*32 +: 32] = next_rand();
		for (int i = 0; i < 128; i++)
			stat_mem[i] = {next_rand(), next_rand()};

		// reset values at the end of the reset period, before any read
		repeat (10) @(posedge clk);
		#2;
		compare_word("reset regdout", 32'h0, regdout);
		compare_word("reset rx_clr_en", 32'h0, {31'h0, rx_clr_en});
		compare_word("reset tx_clr_en", 32'h0, {31'h0, tx_clr_en});
		reset_ = 1'b1;

		// random regular reads with random page and clear off
		sys_addr = 4'h3;
		for (int n = 0; n < REGU_READS; n++)
		begin
			r = next_rand();
			a = {r[19:16], 2'b00, regu_addr_pick(int'(r[7:0]) % 18)};
			host_read(a, model_word(a), "regu_rand");
		end

		// stat group reads of both halves
		for (int n = 0; n < STAT_READS; n++)
		begin
			r = next_rand();
			a = {r[19:16], 2'b10, r[9:2], 2'b00};
			host_read(a, model_word(a), "stat_rand");
		end

		// ==============================
		// atomic 64 bit reads
		// ==============================
		old_hi = regu_cnt.rx_pkt_hi;
		host_read(16'h0028, model_word(16'h0028), "atomic_pkt_lo");
		regu_cnt.rx_pkt_hi = next_rand();
		for (int i = 0; i < 128; i++)
			stat_mem[i] = {next_rand(), next_rand()};
		host_read(16'h002c, old_hi, "atomic_pkt_hi");
		host_read(16'h002c, regu_cnt.rx_pkt_hi, "atomic_pkt_hi_live");

		old_hi = regu_cnt.rx_byte_hi;
		host_read(16'h0038, model_word(16'h0038), "atomic_byte_lo");
		regu_cnt.rx_byte_hi = next_rand();
		host_read(16'h003c, old_hi, "atomic_byte_hi");
		host_read(16'h003c, regu_cnt.rx_byte_hi, "atomic_byte_hi_live");

		a = 16'h0a50;                   // stat group entry 0x4a
		old_hi = stat_mem[a[9:3]][63:32];
		host_read(a, model_word(a), "atomic_stat_lo");
		stat_mem[a[9:3]] = {next_rand(), next_rand()};
		host_read(a | 16'h0004, old_hi, "atomic_stat_hi");
		host_read(a | 16'h0004, model_word(a | 16'h0004), "atomic_stat_hi_live");

		// tag mismatch gives the live word
		host_read(16'h0028, model_word(16'h0028), "mismatch_lo");
		regu_cnt.rx_pkt_hi  = next_rand();
		regu_cnt.rx_byte_hi = next_rand();
		host_read(16'h003c, regu_cnt.rx_byte_hi, "mismatch_hi");

		// ==============================
		// clear on read
		// ==============================
		sys_addr       = 4'h5;
		rx_auto_clr_en = 1'b1;
		host_read(16'h5020, model_word(16'h5020), "clr_rx");
		rx_auto_clr_en = 1'b0;
		tx_auto_clr_en = 1'b1;
		host_read(16'h5030, model_word(16'h5030), "clr_tx");
		rx_auto_clr_en = 1'b1;
		host_read(16'h5840, model_word(16'h5840), "clr_both");
		host_read(16'h6020, model_word(16'h6020), "clr_page_miss");
		rx_auto_clr_en = 1'b0;
		tx_auto_clr_en = 1'b0;
		host_read(16'h5000, model_word(16'h5000), "clr_disabled");

		if (err_cnt == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+source
source/fmac_stat_pkg.sv
source/fmac_addr_decode.sv
source/fmac_counter_mux.sv
source/fmac_atomic_hi.sv
source/fmac_stat_regs.sv
dv/fmac_stat_props.sv
dv/fmac_stat_tb.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the fmac statistics read port testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --assert --timing \
	-f build.f \
	--top-module fmac_stat_tb \
	-o sim_fmac_stat

# the simulation may stop on $fatal, the log decides the result
./obj_dir/sim_fmac_stat > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation finished: FAIL" sim.log; then
	exit 1
fi
grep -q "Simulation finished: PASS" sim.log
